/* include/rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

`define XLEN         32
`define REG_IDX_W    5
`define OPCODE_W     7
`define FUNC3_W      3
`define FUNC7_W      7
`define LOAD_TYPE_W  3
`define STORE_TYPE_W 2

// base opcodes of the rv32i instruction groups.
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011

`define LOAD_NONE 3'b111

// bubble is an addi x0 with no side effects.
`define ID_EX_BUBBLE  '{opcode: `OP_IMM, mem_load_type: `LOAD_NONE, default: '0}
`define EX_MEM_BUBBLE '{mem_load_type: `LOAD_NONE, default: '0}

`endif

/* list.f */
+incdir+include
src/rv_pkg.sv
src/id_ex_pipeline.sv
src/ex_control.sv
src/alu.sv
src/branch_unit.sv
src/ex_mem_pipeline.sv
src/ex_stage.sv
verif/ex_stage_assertions.sv
verif/ex_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the ex_stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module ex_stage_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vex_stage_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module alu
    import rv_pkg::*;
(
    input  id_ex_t   ex_q,
    input  ex_mem_t  ex_mem,
    input  wb_t      wb,
    input  fwd_sel_e fwd_a,
    input  fwd_sel_e fwd_b,
    input  alu_op_e  alu_op,
    output word_t    op_a_fwd,
    output word_t    op_b_fwd,
    output word_t    result
);

    word_t      a_in;
    word_t      b_in;
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    always_comb begin
        unique case (fwd_a)
            FWD_EX_MEM: op_a_fwd = ex_mem.alu_result;
            FWD_WB:     op_a_fwd = wb.data;
            default:    op_a_fwd = ex_q.op1;
        endcase
    end

    always_comb begin
        unique case (fwd_b)
            FWD_EX_MEM: op_b_fwd = ex_mem.alu_result;
            FWD_WB:     op_b_fwd = wb.data;
            default:    op_b_fwd = ex_q.op2;
        endcase
    end

    // auipc and jal add to the pc of the instruction itself.
    assign a_in = (ex_q.opcode == `OP_AUIPC || ex_q.opcode == `OP_JAL) ? ex_q.pc : op_a_fwd;
    assign b_in = ex_q.alu_src ? ex_q.immediate : op_b_fwd;

    assign shamt       = b_in[4:0];
    assign lt_signed   = $signed(a_in) < $signed(b_in);
    assign lt_unsigned = a_in < b_in;

    always_comb begin
        unique case (alu_op)
            ALU_ADD:    result = a_in + b_in;
            ALU_SUB:    result = a_in - b_in;
            ALU_SLL:    result = a_in << shamt;
            ALU_SLT:    result = {{(`XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:    result = a_in ^ b_in;
            ALU_SRL:    result = a_in >> shamt;
            ALU_SRA:    result = word_t'($signed(a_in) >>> shamt);
            ALU_OR:     result = a_in | b_in;
            ALU_AND:    result = a_in & b_in;
            default:    result = b_in;
        endcase
    end

endmodule

`default_nettype wire

/* src/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module branch_unit
    import rv_pkg::*;
(
    input  id_ex_t ex_q,
    input  word_t  op_a_fwd,
    input  word_t  op_b_fwd,
    output logic   taken,
    output word_t  target,
    output word_t  link_value
);

    logic equal;
    logic lt_signed;
    logic lt_unsigned;
    logic cond;

    assign equal       = (op_a_fwd == op_b_fwd);
    assign lt_signed   = $signed(op_a_fwd) < $signed(op_b_fwd);
    assign lt_unsigned = op_a_fwd < op_b_fwd;

    always_comb begin
        unique case (ex_q.func3)
            3'b000:  cond = equal;
            3'b001:  cond = !equal;
            3'b100:  cond = lt_signed;
            3'b101:  cond = !lt_signed;
            3'b110:  cond = lt_unsigned;
            3'b111:  cond = !lt_unsigned;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        if (ex_q.opcode == `OP_JAL || ex_q.opcode == `OP_JALR) begin
            taken = 1'b1;
        end else if (ex_q.opcode == `OP_BRANCH) begin
            taken = cond;
        end else begin
            taken = 1'b0;
        end
    end

    // jalr drops bit 0 of the computed address.
    assign target = (ex_q.opcode == `OP_JALR) ?
                    ((op_a_fwd + ex_q.immediate) & ~word_t'(1)) :
                    (ex_q.pc + ex_q.immediate);

    assign link_value = ex_q.pc + word_t'(4);

endmodule

`default_nettype wire

/* src/ex_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module ex_control
    import rv_pkg::*;
(
    input  id_ex_t   ex_q,
    input  ex_mem_t  ex_mem,
    input  wb_t      wb,
    input  logic     taken,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b,
    output alu_op_e  alu_op,
    output logic     flush
);

    // ex/mem wins over wb; loads in ex/mem have no data yet.
    function automatic fwd_sel_e pick_source(reg_idx_t rs, ex_mem_t em, wb_t w);
        fwd_sel_e sel;
        sel = FWD_NONE;
        if (em.wb_reg_file && !em.wb_load && em.wb_rd != '0 && em.wb_rd == rs) begin
            sel = FWD_EX_MEM;
        end else if (w.reg_write && w.rd != '0 && w.rd == rs) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    logic is_reg;

    assign is_reg = (ex_q.opcode == `OP_REG);

    always_comb begin
        // auipc, loads, stores and jumps all add.
        alu_op = ALU_ADD;
        if (is_reg || ex_q.opcode == `OP_IMM) begin
            unique case (ex_q.func3)
                3'b000:  alu_op = (is_reg && ex_q.func7[5]) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = ex_q.func7[5] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end else if (ex_q.opcode == `OP_LUI) begin
            alu_op = ALU_PASS_B;
        end
    end

    assign fwd_a = pick_source(ex_q.rs1, ex_mem, wb);
    assign fwd_b = pick_source(ex_q.rs2, ex_mem, wb);

    assign flush = taken;

endmodule

`default_nettype wire

/* src/ex_mem_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module ex_mem_pipeline
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  id_ex_t  ex_q,
    input  word_t   result,
    input  word_t   store_data,
    input  word_t   link_value,
    input  word_t   target,
    input  logic    taken,
    output ex_mem_t ex_mem
);

    ex_mem_t nxt;
    logic    is_jump;

    assign is_jump = (ex_q.opcode == `OP_JAL) || (ex_q.opcode == `OP_JALR);

    always_comb begin
        nxt.alu_result     = is_jump ? link_value : result;
        nxt.store_data     = store_data;
        nxt.mem_write      = ex_q.mem_write;
        nxt.mem_load_type  = ex_q.mem_load_type;
        nxt.mem_store_type = ex_q.mem_store_type;
        nxt.wb_load        = ex_q.wb_load;
        nxt.wb_reg_file    = ex_q.wb_reg_file;
        nxt.wb_rd          = ex_q.wb_rd;
        nxt.branch_taken   = taken;
        nxt.branch_target  = target;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_mem <= `EX_MEM_BUBBLE;
        end else begin
            ex_mem <= nxt;
        end
    end

endmodule

`default_nettype wire

/* src/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  id_ex_t  id,
    input  wb_t     wb,
    output ex_mem_t ex_mem,
    output logic    flush
);

    id_ex_t   ex_q;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    alu_op_e  alu_op;
    word_t    op_a_fwd;
    word_t    op_b_fwd;
    word_t    result;
    word_t    target;
    word_t    link_value;
    logic     taken;

    id_ex_pipeline id_ex_pipeline_inst (
        .clk   (clk),
        .rst   (rst),
        .id    (id),
        .flush (flush),
        .ex_q  (ex_q)
    );

    ex_control ex_control_inst (
        .ex_q   (ex_q),
        .ex_mem (ex_mem),
        .wb     (wb),
        .taken  (taken),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b),
        .alu_op (alu_op),
        .flush  (flush)
    );

    alu alu_inst (
        .ex_q     (ex_q),
        .ex_mem   (ex_mem),
        .wb       (wb),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .alu_op   (alu_op),
        .op_a_fwd (op_a_fwd),
        .op_b_fwd (op_b_fwd),
        .result   (result)
    );

    branch_unit branch_unit_inst (
        .ex_q       (ex_q),
        .op_a_fwd   (op_a_fwd),
        .op_b_fwd   (op_b_fwd),
        .taken      (taken),
        .target     (target),
        .link_value (link_value)
    );

    // forwarded rs2 is the store data.
    ex_mem_pipeline ex_mem_pipeline_inst (
        .clk        (clk),
        .rst        (rst),
        .ex_q       (ex_q),
        .result     (result),
        .store_data (op_b_fwd),
        .link_value (link_value),
        .target     (target),
        .taken      (taken),
        .ex_mem     (ex_mem)
    );

endmodule

`default_nettype wire

/* src/id_ex_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module id_ex_pipeline
    import rv_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  id_ex_t id,
    input  logic   flush,
    output id_ex_t ex_q
);

    // a flushed slot becomes a bubble so nothing is written later on.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_q <= `ID_EX_BUBBLE;
        end else if (flush) begin
            ex_q <= `ID_EX_BUBBLE;
        end else begin
            ex_q <= id;
        end
    end

endmodule

`default_nettype wire

/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    `include "rv_macros.svh"

    typedef logic [`XLEN-1:0]         word_t;
    typedef logic [`REG_IDX_W-1:0]    reg_idx_t;
    typedef logic [`OPCODE_W-1:0]     opcode_t;
    typedef logic [`FUNC3_W-1:0]      func3_t;
    typedef logic [`FUNC7_W-1:0]      func7_t;
    typedef logic [`LOAD_TYPE_W-1:0]  load_type_t;
    typedef logic [`STORE_TYPE_W-1:0] store_type_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EX_MEM,
        FWD_WB
    } fwd_sel_e;

    // decoded instruction as handed over by the decode stage.
    typedef struct packed {
        word_t       pc;
        word_t       op1;
        word_t       op2;
        word_t       immediate;
        opcode_t     opcode;
        logic        alu_src;
        func7_t      func7;
        func3_t      func3;
        logic        mem_write;
        load_type_t  mem_load_type;
        store_type_t mem_store_type;
        logic        wb_load;
        logic        wb_reg_file;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        reg_idx_t    wb_rd;
    } id_ex_t;

    typedef struct packed {
        word_t       alu_result;
        word_t       store_data;
        logic        mem_write;
        load_type_t  mem_load_type;
        store_type_t mem_store_type;
        logic        wb_load;
        logic        wb_reg_file;
        reg_idx_t    wb_rd;
        logic        branch_taken;
        word_t       branch_target;
    } ex_mem_t;

    typedef struct packed {
        logic     reg_write;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

`default_nettype wire

/* verif/ex_stage_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage_assertions
    import rv_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     flush,
    input ex_mem_t  ex_mem,
    input id_ex_t   ex_q,
    input fwd_sel_e fwd_a,
    input fwd_sel_e fwd_b
);

    reset_quiet: assert property (@(posedge clk)
        (rst || $fell(rst)) |-> (!flush && !ex_mem.wb_reg_file && !ex_mem.mem_write))
        else $error("flush or an ex_mem write seen around reset");

    // the slot after a flush must be a bubble.
    flush_bubble: assert property (@(posedge clk) disable iff (rst)
        flush |=> (!ex_q.wb_reg_file && !ex_q.mem_write))
        else $error("id/ex register not a bubble after flush");

    no_load_forward: assert property (@(posedge clk) disable iff (rst)
        ex_mem.wb_load |-> (fwd_a != FWD_EX_MEM && fwd_b != FWD_EX_MEM))
        else $error("load result forwarded from ex/mem");

endmodule

bind ex_stage ex_stage_assertions ex_stage_assertions_inst (
    .clk    (clk),
    .rst    (rst),
    .flush  (flush),
    .ex_mem (ex_mem),
    .ex_q   (ex_q),
    .fwd_a  (fwd_a),
    .fwd_b  (fwd_b)
);

`default_nettype wire

/* verif/ex_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module ex_stage_tb
    import rv_pkg::*;
;

    typedef struct packed {
        id_ex_t   id;
        wb_t      wb;
        word_t    res;
        word_t    store_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_write;
        logic     taken;
        word_t    target;
        logic     flush;
    } vector_t;

    logic    clk;
    logic    rst;
    id_ex_t  id;
    wb_t     wb;
    ex_mem_t ex_mem;
    logic    flush;

    vector_t vecs[$];
    word_t   fields[$];
    int      test_errs[$];
    int      load_errs;
    int      tests_run;
    int      tests_failed;
    int      timeout_ns;
    bit      loaded;
    id_ex_t  exp_id;

    ex_stage ex_stage_inst (
        .clk    (clk),
        .rst    (rst),
        .id     (id),
        .wb     (wb),
        .ex_mem (ex_mem),
        .flush  (flush)
    );

    always #50 clk = ~clk;

    // splits one text line into its hex columns.
    task automatic split_fields(string line);
        int    start;
        int    code;
        byte   ch;
        string tok;
        word_t val;
        fields.delete();
        start = -1;
        for (int k = 0; k <= line.len(); k++) begin
            ch = (k < line.len()) ? line.getc(k) : 8'h20;
            if (ch == " " || ch == "\t" || ch == "\n" || ch == "\r") begin
                if (start >= 0) begin
                    tok = line.substr(start, k - 1);
                    code = $sscanf(tok, "%h", val);
                    if (code == 1) begin
                        fields.push_back(val);
                    end
                    start = -1;
                end
            end else if (start < 0) begin
                start = k;
            end
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          code;
        string       line;
        logic [31:0] col [0:26];
        vector_t     v;
        fd = $fopen("verif/ex_stage_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file");
            load_errs++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code != 0 && line.getc(0) != "#") begin
                    split_fields(line);
                    if (fields.size() == 27) begin
                        foreach (col[j]) begin
                            col[j] = fields[j];
                        end
                        v.id.pc             = col[0];
                        v.id.op1            = col[1];
                        v.id.op2            = col[2];
                        v.id.immediate      = col[3];
                        v.id.opcode         = col[4][6:0];
                        v.id.alu_src        = col[5][0];
                        v.id.func7          = col[6][6:0];
                        v.id.func3          = col[7][2:0];
                        v.id.mem_write      = col[8][0];
                        v.id.mem_load_type  = col[9][2:0];
                        v.id.mem_store_type = col[10][1:0];
                        v.id.wb_load        = col[11][0];
                        v.id.wb_reg_file    = col[12][0];
                        v.id.rs1            = col[13][4:0];
                        v.id.rs2            = col[14][4:0];
                        v.id.wb_rd          = col[15][4:0];
                        v.wb.reg_write      = col[16][0];
                        v.wb.rd             = col[17][4:0];
                        v.wb.data           = col[18];
                        v.res               = col[19];
                        v.store_data        = col[20];
                        v.rd                = col[21][4:0];
                        v.reg_write         = col[22][0];
                        v.mem_write         = col[23][0];
                        v.taken             = col[24][0];
                        v.target            = col[25];
                        v.flush             = col[26][0];
                        vecs.push_back(v);
                    end else if (fields.size() != 0) begin
                        $display("malformed line in the vector file: %s", line);
                        load_errs++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // prints a mismatch and returns 1 for it.
    function automatic int count_mismatch(string who, string name, word_t got, word_t exp);
        int bad;
        bad = 0;
        if (got !== exp) begin
            $display("Fail at %0d ns: %s %s expected %h got %h",
                     $time, who, name, exp, got);
            bad = 1;
        end
        return bad;
    endfunction

    task automatic compare_value(int idx, string name, word_t got, word_t exp);
        test_errs[idx] = test_errs[idx] +
                         count_mismatch($sformatf("test %0d", idx), name, got, exp);
    endtask

    task automatic check_reset(string when);
        int    errs;
        string who;
        who = {"reset check ", when};
        errs = 0;
        errs += count_mismatch(who, "wb_reg_file", word_t'(ex_mem.wb_reg_file), '0);
        errs += count_mismatch(who, "mem_write", word_t'(ex_mem.mem_write), '0);
        errs += count_mismatch(who, "mem_load_type", word_t'(ex_mem.mem_load_type),
                               word_t'(`LOAD_NONE));
        errs += count_mismatch(who, "branch_taken", word_t'(ex_mem.branch_taken), '0);
        errs += count_mismatch(who, "flush", word_t'(flush), '0);
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("reset check %s %s", when, (errs == 0) ? "passed" : "failed");
    endtask

    task automatic finish_test(int idx);
        tests_run++;
        if (test_errs[idx] != 0) begin
            tests_failed++;
        end
        $display("test %0d %s", idx, (test_errs[idx] == 0) ? "passed" : "failed");
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        id = `ID_EX_BUBBLE;
        wb = '0;
        tests_run = 0;
        tests_failed = 0;
        load_errs = 0;
        loaded = 1'b0;
        load_vectors();
        if (load_errs != 0) begin
            tests_failed = tests_failed + 1;
        end
        foreach (vecs[k]) begin
            test_errs.push_back(0);
        end
        loaded = 1'b1;

        repeat (5) @(posedge clk);
        @(negedge clk);
        check_reset("during reset");
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_reset("after reset");

        // wb fields of a line are driven while that line is in EX.
        for (int i = 0; i < vecs.size() + 2; i++) begin
            @(posedge clk);
            if (i < vecs.size()) begin
                id <= vecs[i].id;
            end else begin
                id <= `ID_EX_BUBBLE;
            end
            if (i >= 1 && i <= vecs.size()) begin
                wb <= vecs[i-1].wb;
            end else begin
                wb <= '0;
            end
            @(negedge clk);
            if (i >= 1 && i <= vecs.size()) begin
                compare_value(i - 1, "flush", word_t'(flush), word_t'(vecs[i-1].flush));
            end
            if (i >= 2) begin
                // a slot behind a flush reaches ex/mem as a bubble.
                if (i >= 3 && vecs[i-3].flush) begin
                    exp_id = `ID_EX_BUBBLE;
                end else begin
                    exp_id = vecs[i-2].id;
                end
                compare_value(i - 2, "alu_result", ex_mem.alu_result, vecs[i-2].res);
                compare_value(i - 2, "store_data", ex_mem.store_data, vecs[i-2].store_data);
                compare_value(i - 2, "wb_rd", word_t'(ex_mem.wb_rd), word_t'(vecs[i-2].rd));
                compare_value(i - 2, "wb_reg_file", word_t'(ex_mem.wb_reg_file),
                              word_t'(vecs[i-2].reg_write));
                compare_value(i - 2, "mem_write", word_t'(ex_mem.mem_write),
                              word_t'(vecs[i-2].mem_write));
                compare_value(i - 2, "mem_load_type", word_t'(ex_mem.mem_load_type),
                              word_t'(exp_id.mem_load_type));
                compare_value(i - 2, "mem_store_type", word_t'(ex_mem.mem_store_type),
                              word_t'(exp_id.mem_store_type));
                compare_value(i - 2, "wb_load", word_t'(ex_mem.wb_load),
                              word_t'(exp_id.wb_load));
                compare_value(i - 2, "branch_taken", word_t'(ex_mem.branch_taken),
                              word_t'(vecs[i-2].taken));
                compare_value(i - 2, "branch_target", ex_mem.branch_target, vecs[i-2].target);
                finish_test(i - 2);
            end
        end

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && vecs.size() != 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog sized from the vector count.
    initial begin
        wait (loaded);
        timeout_ns = (vecs.size() + 20) * 100;
        #(timeout_ns);
        $display("the run timed out after %0d ns", timeout_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/ex_stage_tests.txt */
# pc op1 op2 imm opcode alu_src func7 func3 mem_write load_type store_type wb_load wb_reg_file rs1 rs2 rd
# wb: reg_write rd data | expected: result store_data rd reg_write mem_write taken target flush
0 5 7 0 33 0 0 0 0 7 0 0 1 a b 1 0 0 0 c 7 1 1 0 0 0 0
0 3 5 0 33 0 20 0 0 7 0 0 1 c d 2 0 0 0 fffffffe 5 2 1 0 0 0 0
0 1 24 0 33 0 0 1 0 7 0 0 1 c d 3 0 0 0 10 24 3 1 0 0 0 0
0 ffffffff 1 0 33 0 0 2 0 7 0 0 1 c d 4 0 0 0 1 1 4 1 0 0 0 0
0 ffffffff 1 0 33 0 0 3 0 7 0 0 1 c d 5 0 0 0 0 1 5 1 0 0 0 0
0 f0f0f0f0 ff00ff00 0 33 0 0 4 0 7 0 0 1 c d 6 0 0 0 0ff00ff0 ff00ff00 6 1 0 0 0 0
0 80000000 4 0 33 0 0 5 0 7 0 0 1 c d 7 0 0 0 08000000 4 7 1 0 0 0 0
0 80000000 4 0 33 0 20 5 0 7 0 0 1 c d 8 0 0 0 f8000000 4 8 1 0 0 0 0
0 f0 f 0 33 0 0 6 0 7 0 0 1 c d 9 0 0 0 ff f 9 1 0 0 0 0
0 ff0 ff 0 33 0 0 7 0 7 0 0 1 c d a 0 0 0 f0 ff a 1 0 0 0 0
0 10 0 fffffff0 13 1 20 0 0 7 0 0 1 e 0 11 0 0 0 0 0 11 1 0 0 fffffff0 0
0 fffffffb 0 3 13 1 0 2 0 7 0 0 1 e 0 12 0 0 0 1 0 12 1 0 0 3 0
0 3 0 ffffffff 13 1 0 3 0 7 0 0 1 e 0 13 0 0 0 1 0 13 1 0 0 ffffffff 0
0 ff 0 ffffffff 13 1 0 4 0 7 0 0 1 e 0 14 0 0 0 ffffff00 0 14 1 0 0 ffffffff 0
0 100 0 ff 13 1 0 6 0 7 0 0 1 e 0 15 0 0 0 1ff 0 15 1 0 0 ff 0
0 1ff 0 f0 13 1 0 7 0 7 0 0 1 e 0 16 0 0 0 f0 0 16 1 0 0 f0 0
0 3 0 1f 13 1 0 1 0 7 0 0 1 e 0 17 0 0 0 80000000 0 17 1 0 0 1f 0
0 ffffffff 0 1c 13 1 0 5 0 7 0 0 1 e 0 18 0 0 0 f 0 18 1 0 0 1c 0
0 80000000 0 41f 13 1 20 5 0 7 0 0 1 e 0 19 0 0 0 ffffffff 0 19 1 0 0 41f 0
0 0 0 12345000 37 1 0 0 0 7 0 0 1 0 0 1a 0 0 0 12345000 0 1a 1 0 0 12345000 0
1000 0 0 2000 17 1 0 0 0 7 0 0 1 0 0 1b 0 0 0 3000 0 1b 1 0 0 3000 0
0 7 0 1 13 1 0 0 0 7 0 0 1 0 0 5 0 0 0 8 0 5 1 0 0 1 0
0 0 0 0 33 0 0 0 0 7 0 0 1 5 5 6 0 0 0 10 8 6 1 0 0 0 0
0 100 0 4 03 1 0 2 0 2 0 1 1 0 0 7 0 0 0 104 0 7 1 0 0 4 0
0 0 10 0 33 0 0 0 0 7 0 0 1 7 6 8 1 7 55 65 10 8 1 0 0 0 0
0 0 0 0 33 0 0 0 0 7 0 0 1 8 0 9 1 8 99 65 0 9 1 0 0 0 0
0 0 0 1 13 1 0 0 0 7 0 0 1 3 0 a 1 3 20 21 0 a 1 0 0 1 0
0 5 0 5 13 1 0 0 0 7 0 0 1 0 0 0 0 0 0 a 0 0 1 0 0 5 0
0 0 0 0 33 0 0 0 0 7 0 0 1 0 0 c 1 0 77 0 0 c 1 0 0 0 0
0 200 0 8 23 1 0 2 1 7 2 0 0 0 f 0 1 f 1234 208 1234 0 0 1 0 8 0
100 5 5 20 63 0 0 0 0 7 0 0 0 0 0 0 0 0 0 a 5 0 0 0 1 120 1
0 1 3 1 23 1 0 2 1 7 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
200 5 5 40 63 0 0 1 0 7 0 0 0 0 0 0 0 0 0 a 5 0 0 0 0 240 0
300 ffffffff 1 10 63 0 0 4 0 7 0 0 0 0 0 0 0 0 0 0 1 0 0 0 1 310 1
0 1 1 0 33 0 0 0 0 7 0 0 1 0 0 2 0 0 0 0 0 0 0 0 0 0 0
400 ffffffff 1 8 63 0 0 5 0 7 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 408 0
500 ffffffff 1 8 63 0 0 6 0 7 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 508 0
600 ffffffff 1 c 63 0 0 7 0 7 0 0 0 0 0 0 0 0 0 0 1 0 0 0 1 60c 1
0 9 0 1 13 1 0 0 0 7 0 0 1 0 0 3 0 0 0 0 0 0 0 0 0 0 0
700 0 0 100 6f 1 0 0 0 7 0 0 1 0 0 1 0 0 0 704 0 1 1 0 1 800 1
0 2 0 2 13 1 0 0 0 7 0 0 1 0 0 4 0 0 0 0 0 0 0 0 0 0 0
800 1001 0 6 67 1 0 0 0 7 0 0 1 0 0 2 0 0 0 804 0 2 1 0 1 1006 1
0 2 0 2 13 1 0 0 0 7 0 0 1 0 0 5 0 0 0 0 0 0 0 0 0 0 0
0 2 0 3 13 1 0 0 0 7 0 0 1 0 0 4 0 0 0 5 0 4 1 0 0 3 0
